/* build.f */
hdl/ice_bus_pkg.sv
hdl/ice_cfg_pkg.sv
hdl/uart.sv
hdl/ice_bus_ctrl.sv
hdl/basics_regs.sv
hdl/ein_serializer.sv
hdl/ice_top.sv
verification/ice_top_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the ICE bus testbench with Verilator, run it and judge the log

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f build.f --top-module ice_top_tb -o ice_top_tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/ice_top_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "SIMULATION PASSED" "$LOG"; then
	exit 0
fi
exit 1

/* verification/ice_top_tb.sv */
`default_nettype none

module ice_top_tb;
	import ice_bus_pkg::*;
	import ice_cfg_pkg::*;

	localparam int BAUD_DIV = 8;
	localparam time CLK_PERIOD = 8;
	localparam int RESP_TIMEOUT = 4000;

	logic clk;
	logic reset;
	logic uart_rx;
	wire uart_tx;
	wire ein_edi;
	wire ein_eci;
	wire ein_emo;

	int mismatches;
	int timeouts;
	int protocol_errors;
	integer seed;

	// Expected response bytes and modelled event counter
	ice_char_t exp_q [$];
	ice_char_t model_cnt;
	ice_char_t pay [0:15];

	// Host UART receiver state
	logic mon_busy;
	int mon_wait;
	int mon_bit;
	ice_char_t mon_shift;

	// EIN monitor state
	ice_char_t ein_q [$];
	ein_div_t half_q [$];
	ice_char_t ein_shift;
	int ein_bits;
	time rise_t;
	bit rise_seen;

	ice_top #(
		.BAUD_DIV(BAUD_DIV)
	) uut (
		.clk(clk),
		.reset(reset),
		.uart_rx(uart_rx),
		.uart_tx(uart_tx),
		.ein_edi(ein_edi),
		.ein_eci(ein_eci),
		.ein_emo(ein_emo)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check_char(input ice_char_t actual, input ice_char_t expected,
			input string what);
		if (actual !== expected) begin
			$display("Mismatch at time %0t: %s got %02h expected %02h",
				$time, what, actual, expected);
			mismatches++;
		end
	endtask

	task automatic check_div(input ein_div_t actual, input ein_div_t expected,
			input string what);
		if (actual !== expected) begin
			$display("Mismatch at time %0t: %s got %0d expected %0d",
				$time, what, actual, expected);
			mismatches++;
		end
	endtask

	// Response frame as the host expects it
	function automatic int expected_response(input ice_char_t ftype, input ice_char_t fid,
			input ice_char_t count, output ice_char_t resp [0:5]);
		logic known;
		int n;
		known = (ftype == FRAME_VERSION) || (ftype == FRAME_CONFIG) || (ftype == FRAME_EIN);
		for (int i = 0; i < 6; i++)
			resp[i] = 8'h00;
		resp[0] = known ? RESP_ACK : RESP_NAK;
		resp[1] = fid;
		resp[2] = 8'd0;
		n = 3;
		// Only the version query carries data
		if (ftype == FRAME_VERSION) begin
			resp[2] = 8'd3;
			resp[3] = ICE_VERSION[15:8];
			resp[4] = ICE_VERSION[7:0];
			resp[5] = count;
			n = 6;
		end
		return n;
	endfunction

	// Host receiver on uart_tx, compares each byte as it lands
	always @(negedge clk) begin
		if (reset) begin
			mon_busy = 1'b0;
		end else if (!mon_busy) begin
			if (!uart_tx) begin
				mon_busy = 1'b1;
				// Centre of data bit 0
				mon_wait = BAUD_DIV + BAUD_DIV / 2;
				mon_bit = 0;
			end
		end else begin
			mon_wait = mon_wait - 1;
			if (mon_wait == 0) begin
				if (mon_bit < 8) begin
					// LSB first on the wire
					mon_shift = {uart_tx, mon_shift[7:1]};
					mon_bit++;
					mon_wait = BAUD_DIV;
				end else begin
					mon_busy = 1'b0;
					if (!uart_tx) begin
						$display("Framing error: stop bit low on uart_tx at time %0t", $time);
						protocol_errors++;
					end else if (exp_q.size() == 0) begin
						$display("Unexpected response byte %02h at time %0t", mon_shift, $time);
						protocol_errors++;
					end else begin
						check_char(mon_shift, exp_q.pop_front(), "response byte");
					end
				end
			end
		end
	end

	// EIN data sampled on rising ECI
	always @(posedge ein_eci) begin
		rise_t = $time;
		rise_seen = 1'b1;
		check_char({7'b0, ein_emo}, 8'h01, "EMO at ECI rise");
		// MSB arrives first
		ein_shift = {ein_shift[6:0], ein_edi};
		ein_bits++;
		if (ein_bits == 8) begin
			ein_q.push_back(ein_shift);
			ein_bits = 0;
		end
	end

	// High phase length in clock cycles
	always @(negedge ein_eci) begin
		if (rise_seen) begin
			half_q.push_back(ein_div_t'(($time - rise_t) / CLK_PERIOD));
			rise_seen = 1'b0;
		end
	end

	task automatic send_byte(input ice_char_t b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			#1 uart_rx = frame[i];
			repeat (BAUD_DIV - 1) @(posedge clk);
		end
		// Extra idle after the stop bit lets the receiver rearm
		repeat (2) @(posedge clk);
	endtask

	task automatic wait_response();
		int cycles;
		cycles = 0;
		while ((exp_q.size() != 0 || mon_busy) && cycles < RESP_TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		if (exp_q.size() != 0 || mon_busy) begin
			$display("Timeout: response frame incomplete with %0d bytes still expected",
				exp_q.size());
			timeouts++;
			exp_q.delete();
		end
		// Rest of the stop bit and the counter update
		repeat (BAUD_DIV) @(posedge clk);
	endtask

	task automatic check_idle(input string what);
		@(negedge clk);
		check_char({5'b0, uart_tx, ein_eci, ein_emo}, 8'h04, what);
	endtask

	task automatic run_frame(input ice_char_t ftype, input ice_char_t fid,
			input ice_len_t len);
		ice_char_t exp_bytes [0:5];
		int n;
		n = expected_response(ftype, fid, model_cnt, exp_bytes);
		for (int i = 0; i < n; i++)
			exp_q.push_back(exp_bytes[i]);
		ein_q.delete();
		half_q.delete();
		ein_bits = 0;
		send_byte(ftype);
		send_byte(fid);
		send_byte(len);
		for (int i = 0; i < int'(len); i++)
			send_byte(pay[i]);
		wait_response();
		// Every finished response bumps the counter
		model_cnt = model_cnt + 8'd1;
		check_idle("idle {uart_tx, eci, emo} after frame");
	endtask

	task automatic fill_random(input int len);
		for (int i = 0; i < len; i++)
			pay[i] = ice_char_t'($random(seed));
	endtask

	task automatic check_ein(input ice_len_t len, input ein_div_t div);
		check_char(ice_char_t'(ein_q.size()), len, "EIN byte count");
		for (int i = 0; i < ein_q.size() && i < int'(len); i++)
			check_char(ein_q[i], pay[i], "EIN byte");
		check_char(ice_char_t'(half_q.size()), ice_char_t'(8 * int'(len)), "ECI pulse count");
		for (int i = 0; i < half_q.size(); i++)
			check_div(half_q[i], div, "ECI high phase cycles");
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		uart_rx = 1'b1;
		seed = 32'h3710;
		mismatches = 0;
		timeouts = 0;
		protocol_errors = 0;
		model_cnt = 8'd0;
		ein_bits = 0;
		for (int i = 0; i < 16; i++)
			pay[i] = 8'h00;
		repeat (5) @(posedge clk);
		#1 reset = 1'b0;

		// Outputs quiet after reset
		for (int i = 0; i < 20; i++)
			check_idle("idle {uart_tx, eci, emo} after reset");
		run_frame(FRAME_VERSION, 8'h11, 8'd0);

		// Scratch write then counter readback
		pay[0] = CFG_SCRATCH;
		pay[1] = 8'hA5;
		run_frame(FRAME_CONFIG, 8'h22, 8'd2);
		run_frame(FRAME_VERSION, 8'h23, 8'd0);

		// EIN shift at the reset divider
		fill_random(4);
		run_frame(FRAME_EIN, 8'h31, 8'd4);
		check_ein(8'd4, ein_div_t'(4));

		// New divider seen on the next EIN frame
		pay[0] = CFG_EIN_DIV_LO;
		pay[1] = 8'd3;
		run_frame(FRAME_CONFIG, 8'h41, 8'd2);
		fill_random(3);
		run_frame(FRAME_EIN, 8'h42, 8'd3);
		check_ein(8'd3, ein_div_t'(3));

		// Unknown type gets NAK with no EIN traffic
		fill_random(3);
		run_frame(8'h5A, 8'h51, 8'd3);
		check_ein(8'd0, ein_div_t'(3));
		run_frame(FRAME_VERSION, 8'h52, 8'd0);

		$display("Errors: mismatches=%0d timeouts=%0d protocol=%0d",
			mismatches, timeouts, protocol_errors);
		if (mismatches == 0 && timeouts == 0 && protocol_errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/ice_top.sv */
`default_nettype none

module ice_top #(
	parameter int BAUD_DIV = 8
) (
	input wire clk,
	input wire reset,
	input wire uart_rx,
	output wire uart_tx,
	output wire ein_edi,
	output wire ein_eci,
	output wire ein_emo
);
	import ice_bus_pkg::*;
	import ice_cfg_pkg::*;

	// UART character links
	ice_char_t rx_data;
	logic rx_latch;
	ice_char_t tx_data;
	logic tx_latch;
	logic tx_empty;

	// Config and query links
	logic cfg_we;
	cfg_addr_t cfg_addr;
	ice_char_t cfg_wdata;
	logic [1:0] qry_idx;
	ice_char_t qry_data;
	logic evt_incr;

	// EIN links
	ein_div_t ein_div;
	logic ein_load;
	ice_char_t ein_data;
	logic ein_busy;

	// Host serial link
	uart #(
		.BAUD_DIV(BAUD_DIV)
	) u_uart (
		.clk(clk),
		.reset(reset),
		.rx_in(uart_rx),
		.tx_out(uart_tx),
		.tx_latch(tx_latch),
		.tx_data(tx_data),
		.tx_empty(tx_empty),
		.rx_data(rx_data),
		.rx_latch(rx_latch)
	);

	// Frame parser and response sequencer
	ice_bus_ctrl u_ctrl (
		.clk(clk),
		.reset(reset),
		.rx_char(rx_data),
		.rx_char_valid(rx_latch),
		.tx_char(tx_data),
		.tx_char_valid(tx_latch),
		.tx_char_ready(tx_empty),
		.cfg_we(cfg_we),
		.cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata),
		.qry_idx(qry_idx),
		.qry_data(qry_data),
		.evt_incr(evt_incr),
		.ein_load(ein_load),
		.ein_data(ein_data),
		.ein_busy(ein_busy)
	);

	// Settings, version and event counter
	basics_regs u_basics (
		.clk(clk),
		.reset(reset),
		.cfg_we(cfg_we),
		.cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata),
		.qry_idx(qry_idx),
		.qry_data(qry_data),
		.evt_incr(evt_incr),
		.ein_div(ein_div)
	);

	// Three-wire EIN port
	ein_serializer u_ein (
		.clk(clk),
		.reset(reset),
		.ein_div(ein_div),
		.ein_load(ein_load),
		.ein_data(ein_data),
		.ein_busy(ein_busy),
		.edi(ein_edi),
		.eci(ein_eci),
		.emo(ein_emo)
	);

endmodule

`default_nettype wire

/* hdl/ein_serializer.sv */
`default_nettype none

module ein_serializer (
	input wire clk,
	input wire reset,
	input wire ice_cfg_pkg::ein_div_t ein_div,
	input wire ein_load,
	input wire ice_bus_pkg::ice_char_t ein_data,
	output logic ein_busy,
	output logic edi,
	output logic eci,
	output logic emo
);
	import ice_bus_pkg::*;
	import ice_cfg_pkg::*;

	ice_char_t shift;
	ein_div_t half_cnt;
	logic [2:0] bit_cnt;
	logic active;
	logic half_done;
	logic byte_done;

	// A divider of zero still gives one-cycle halves
	assign half_done = (half_cnt + ein_div_t'(1)) >= ein_div;
	// Final cycle of the high phase of bit 7
	assign byte_done = active & eci & half_done & (bit_cnt == 3'd7);
	// Drops one cycle early so a follow-on load keeps emo high
	assign ein_busy = active & ~byte_done;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			active <= 1'b0;
			eci <= 1'b0;
			emo <= 1'b0;
			edi <= 1'b0;
			half_cnt <= '0;
			bit_cnt <= '0;
		end else if (!active) begin
			if (ein_load) begin
				// MSB presented while ECI is low
				active <= 1'b1;
				emo <= 1'b1;
				eci <= 1'b0;
				edi <= ein_data[7];
				half_cnt <= '0;
				bit_cnt <= '0;
			end else begin
				emo <= 1'b0;
				edi <= 1'b0;
			end
		end else if (half_done) begin
			half_cnt <= '0;
			eci <= ~eci;
			// Falling ECI moves on to the next bit
			if (eci) begin
				if (bit_cnt == 3'd7) begin
					active <= 1'b0;
				end else begin
					bit_cnt <= bit_cnt + 3'd1;
					edi <= shift[6];
				end
			end
		end else begin
			half_cnt <= half_cnt + ein_div_t'(1);
		end
	end

	// Byte shift register, MSB first
	always_ff @(posedge clk) begin
		if (!active && ein_load)
			shift <= ein_data;
		else if (active && half_done && eci)
			shift <= {shift[6:0], 1'b0};
	end

endmodule

`default_nettype wire

/* hdl/basics_regs.sv */
`default_nettype none

module basics_regs (
	input wire clk,
	input wire reset,
	input wire cfg_we,
	input wire ice_cfg_pkg::cfg_addr_t cfg_addr,
	input wire ice_bus_pkg::ice_char_t cfg_wdata,
	input wire [1:0] qry_idx,
	output ice_bus_pkg::ice_char_t qry_data,
	input wire evt_incr,
	output ice_cfg_pkg::ein_div_t ein_div
);
	import ice_bus_pkg::*;
	import ice_cfg_pkg::*;

	ice_char_t scratch;
	// Global event counter, wraps at 255
	ice_char_t evt_count;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ein_div <= ein_div_t'(4);
			scratch <= '0;
			evt_count <= '0;
		end else begin
			if (cfg_we) begin
				case (cfg_addr)
					CFG_EIN_DIV_LO: ein_div[7:0] <= cfg_wdata;
					CFG_EIN_DIV_HI: ein_div[15:8] <= cfg_wdata;
					CFG_SCRATCH: scratch <= cfg_wdata;
					// Unmapped addresses dropped
					default: ;
				endcase
			end
			if (evt_incr)
				evt_count <= evt_count + 8'd1;
		end
	end

	// Query bytes in response order
	always_comb begin
		case (qry_idx)
			2'd0: qry_data = ICE_VERSION[15:8];
			2'd1: qry_data = ICE_VERSION[7:0];
			2'd2: qry_data = evt_count;
			// Index 3 reads back scratch
			default: qry_data = scratch;
		endcase
	end

endmodule

`default_nettype wire

/* hdl/ice_bus_ctrl.sv */
`default_nettype none

module ice_bus_ctrl (
	input wire clk,
	input wire reset,
	input wire ice_bus_pkg::ice_char_t rx_char,
	input wire rx_char_valid,
	output ice_bus_pkg::ice_char_t tx_char,
	output logic tx_char_valid,
	input wire tx_char_ready,
	output logic cfg_we,
	output ice_cfg_pkg::cfg_addr_t cfg_addr,
	output ice_bus_pkg::ice_char_t cfg_wdata,
	output logic [1:0] qry_idx,
	input wire ice_bus_pkg::ice_char_t qry_data,
	output logic evt_incr,
	output logic ein_load,
	output ice_bus_pkg::ice_char_t ein_data,
	input wire ein_busy
);
	import ice_bus_pkg::*;

	ctrl_state_t state;
	ice_char_t frame_type;
	ice_char_t frame_id;
	ice_len_t frame_len;
	ice_len_t pay_cnt;

	// One byte buffer ahead of the EIN serializer
	ice_char_t ein_hold;
	logic ein_pend;

	logic known_type;
	ice_char_t resp_type;
	ice_len_t resp_len;
	logic tx_go;
	logic pay_done;
	logic ein_idle;

	assign known_type = (frame_type == FRAME_VERSION) || (frame_type == FRAME_CONFIG) ||
		(frame_type == FRAME_EIN);
	assign resp_type = known_type ? RESP_ACK : RESP_NAK;
	// Only a version query carries response data
	assign resp_len = (frame_type == FRAME_VERSION) ? 8'd3 : 8'd0;

	// UART free and no latch still in flight
	assign tx_go = tx_char_ready & ~tx_char_valid;
	assign pay_done = (pay_cnt == frame_len);
	// Nothing buffered, nothing being loaded, serializer done
	assign ein_idle = ~ein_pend & ~ein_load & ~ein_busy;

	// FSM and strobes
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= IDLE;
			pay_cnt <= '0;
			ein_pend <= 1'b0;
			ein_load <= 1'b0;
			cfg_we <= 1'b0;
			tx_char_valid <= 1'b0;
			evt_incr <= 1'b0;
			qry_idx <= '0;
		end else begin
			cfg_we <= 1'b0;
			tx_char_valid <= 1'b0;
			evt_incr <= 1'b0;
			ein_load <= 1'b0;
			// Hand buffered byte to the serializer once it frees up
			if (ein_pend && !ein_busy && !ein_load) begin
				ein_load <= 1'b1;
				ein_pend <= 1'b0;
			end
			case (state)
				IDLE: begin
					if (rx_char_valid)
						state <= GET_ID;
				end
				GET_ID: begin
					if (rx_char_valid)
						state <= GET_LEN;
				end
				GET_LEN: begin
					if (rx_char_valid) begin
						pay_cnt <= '0;
						state <= (rx_char == 8'd0) ? SEND_TYPE : GET_PAYLOAD;
					end
				end
				GET_PAYLOAD: begin
					if (pay_done) begin
						// EIN frames answer only after the last bit is out
						if (frame_type != FRAME_EIN || ein_idle)
							state <= SEND_TYPE;
					end else if (rx_char_valid) begin
						pay_cnt <= pay_cnt + 8'd1;
						// Second config byte carries the data
						if (frame_type == FRAME_CONFIG && pay_cnt == 8'd1)
							cfg_we <= 1'b1;
						if (frame_type == FRAME_EIN)
							ein_pend <= 1'b1;
					end
				end
				SEND_TYPE: begin
					if (tx_go) begin
						tx_char_valid <= 1'b1;
						state <= SEND_ID;
					end
				end
				SEND_ID: begin
					if (tx_go) begin
						tx_char_valid <= 1'b1;
						state <= SEND_LEN;
					end
				end
				SEND_LEN: begin
					if (tx_go) begin
						tx_char_valid <= 1'b1;
						qry_idx <= '0;
						state <= SEND_DATA;
					end
				end
				SEND_DATA: begin
					if (tx_go) begin
						// UART idle after the final byte ends the frame
						if (qry_idx == resp_len[1:0]) begin
							evt_incr <= 1'b1;
							state <= IDLE;
						end else begin
							tx_char_valid <= 1'b1;
							qry_idx <= qry_idx + 2'd1;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Frame header and payload capture
	always_ff @(posedge clk) begin
		if (rx_char_valid) begin
			case (state)
				IDLE: frame_type <= rx_char;
				GET_ID: frame_id <= rx_char;
				GET_LEN: frame_len <= rx_char;
				GET_PAYLOAD: begin
					if (!pay_done) begin
						if (pay_cnt == 8'd0)
							cfg_addr <= rx_char;
						if (pay_cnt == 8'd1)
							cfg_wdata <= rx_char;
						ein_hold <= rx_char;
					end
				end
				default: ;
			endcase
		end
		if (ein_pend && !ein_busy && !ein_load)
			ein_data <= ein_hold;
		// Response byte picked by state
		if (tx_go) begin
			case (state)
				SEND_TYPE: tx_char <= resp_type;
				SEND_ID: tx_char <= frame_id;
				SEND_LEN: tx_char <= resp_len;
				SEND_DATA: tx_char <= qry_data;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/uart.sv */
`default_nettype none

module uart #(
	parameter int BAUD_DIV = 8
) (
	input wire clk,
	input wire reset,
	input wire rx_in,
	output logic tx_out,
	input wire tx_latch,
	input wire ice_bus_pkg::ice_char_t tx_data,
	output logic tx_empty,
	output ice_bus_pkg::ice_char_t rx_data,
	output logic rx_latch
);
	import ice_bus_pkg::*;

	// Last cycle of a bit and the mid-bit sample point
	localparam logic [15:0] BIT_LAST = 16'(BAUD_DIV - 1);
	localparam logic [15:0] BIT_MID = 16'(BAUD_DIV / 2);

	logic [1:0] rx_sync;
	logic rx_busy;
	logic [15:0] rx_cnt;
	logic [3:0] rx_bit;
	logic rx_stop;
	ice_char_t rx_shift;

	logic [9:0] tx_shift;
	logic [15:0] tx_cnt;
	logic [3:0] tx_bit;

	// Receiver control
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rx_sync <= 2'b11;
			rx_busy <= 1'b0;
			rx_cnt <= '0;
			rx_bit <= '0;
			rx_latch <= 1'b0;
		end else begin
			rx_sync <= {rx_sync[0], rx_in};
			rx_latch <= 1'b0;
			if (!rx_busy) begin
				// Falling edge on an idle line starts a frame
				if (!rx_sync[1]) begin
					rx_busy <= 1'b1;
					rx_cnt <= '0;
					rx_bit <= '0;
				end
			end else begin
				if (rx_cnt == BIT_LAST) begin
					rx_cnt <= '0;
					if (rx_bit == 4'd9) begin
						// Ten bit times done, hand over only with a good stop bit
						rx_busy <= 1'b0;
						rx_latch <= rx_stop;
					end else begin
						rx_bit <= rx_bit + 4'd1;
					end
				end else begin
					rx_cnt <= rx_cnt + 16'd1;
				end
				// Start bit gone high again at mid-bit means a glitch
				if (rx_cnt == BIT_MID && rx_bit == 4'd0 && rx_sync[1])
					rx_busy <= 1'b0;
			end
		end
	end

	// Receiver data path
	always_ff @(posedge clk) begin
		if (rx_busy && rx_cnt == BIT_MID) begin
			// LSB arrives first
			if (rx_bit >= 4'd1 && rx_bit <= 4'd8)
				rx_shift <= {rx_sync[1], rx_shift[7:1]};
			if (rx_bit == 4'd9)
				rx_stop <= rx_sync[1];
		end
		if (rx_busy && rx_cnt == BIT_LAST && rx_bit == 4'd9)
			rx_data <= rx_shift;
	end

	// Transmitter, start bit in the LSB of the shift register
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			tx_shift <= '1;
			tx_empty <= 1'b1;
			tx_cnt <= '0;
			tx_bit <= '0;
		end else if (tx_empty) begin
			if (tx_latch) begin
				tx_shift <= {1'b1, tx_data, 1'b0};
				tx_empty <= 1'b0;
				tx_cnt <= '0;
				tx_bit <= '0;
			end
		end else if (tx_cnt == BIT_LAST) begin
			tx_cnt <= '0;
			// Shift in ones so the line idles high
			tx_shift <= {1'b1, tx_shift[9:1]};
			if (tx_bit == 4'd9)
				tx_empty <= 1'b1;
			else
				tx_bit <= tx_bit + 4'd1;
		end else begin
			tx_cnt <= tx_cnt + 16'd1;
		end
	end

	assign tx_out = tx_shift[0];

endmodule

`default_nettype wire

/* hdl/ice_cfg_pkg.sv */
`default_nettype none

package ice_cfg_pkg;

	// Configuration register address
	typedef logic [7:0] cfg_addr_t;

	// EIN clock half-period in clk cycles
	typedef logic [15:0] ein_div_t;

	// Register map
	localparam cfg_addr_t CFG_EIN_DIV_LO = 8'd0;
	localparam cfg_addr_t CFG_EIN_DIV_HI = 8'd1;
	localparam cfg_addr_t CFG_SCRATCH = 8'd2;

	// Version reported by a 'V' query, high byte goes first
	localparam logic [15:0] ICE_VERSION = 16'h0103;

endpackage

`default_nettype wire

/* hdl/ice_bus_pkg.sv */
`default_nettype none

package ice_bus_pkg;

	// One UART character or bus byte
	typedef logic [7:0] ice_char_t;

	// Payload byte count of a frame
	typedef logic [7:0] ice_len_t;

	// Frame type codes sent by the host
	localparam ice_char_t FRAME_VERSION = 8'h56;
	localparam ice_char_t FRAME_CONFIG = 8'h63;
	localparam ice_char_t FRAME_EIN = 8'h65;

	// Response type codes
	localparam ice_char_t RESP_ACK = 8'h00;
	localparam ice_char_t RESP_NAK = 8'h01;

	// Bus controller states, receive side then response side
	typedef enum logic [2:0] {
		IDLE,
		GET_ID,
		GET_LEN,
		GET_PAYLOAD,
		SEND_TYPE,
		SEND_ID,
		SEND_LEN,
		SEND_DATA
	} ctrl_state_t;

endpackage

`default_nettype wire
